// File: all.f
blasPkg.sv
ringBuffCtrl.sv
operandQueue.sv
axiLiteRegs.sv
dotAccumulator.sv
dotEngineTop.sv
tbDotEngine.sv

// File: Makefile
# Verilator build and run of the dot-product engine testbench
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tbDotEngine
FILELIST = all.f

BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = PASS: all tests

.PHONY: simulate clean

# The log search decides pass or fail
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tbDotEngine.sv
////////////////////
// Directed tests for dotEngineTop built with DEPTH 8
// Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
// Stops at the first mismatch or handshake timeout
////////////////////
module tbDotEngine import blasPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 8;
	localparam int WAIT_LIMIT = 200;	// Cycles per handshake
	localparam int POLL_LIMIT = 100;	// STATUS reads before giving up
	localparam int STALL_CYCLES = 20;
	localparam logic [1:0] AXI_OKAY = 2'b00;	// AXI4-Lite OKAY response code

	logic clock;
	logic reset;
	logic awvalid;
	logic awready;
	regAddrT awaddr;
	logic wvalid;
	logic wready;
	axiDataT wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	regAddrT araddr;
	logic rvalid;
	logic rready;
	axiDataT rdata;
	logic [1:0] rresp;

	logic [15:0] lfsrState;	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	int modelSum;			// Reference dot product, wraps like int
	bit failed;

	dotEngineTop #(
		.DEPTH(DEPTH)
	) u_dotEngineTop (
		.clock(clock),
		.reset(reset),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;	// 8 ns period
	end

	////////////////////
	// Reporting
	task automatic stopRun();
		failed = 1'b1;
		$display("FAIL: see errors above");
		$fatal(1, "Stopped after the first error");
	endtask

	task automatic timedOut(input string what);
		$display("Timed out waiting for %s", what);
		stopRun();
	endtask

	task automatic checkValue(input string what, input axiDataT got, input axiDataT exp);
		assert (got === exp) else begin
			$display("ERR %0.1f ns: %s is %h, expected %h", $realtime, what, got, exp);
			stopRun();
		end
	endtask

	////////////////////
	// Stimulus and reference model
	function automatic logic nextLfsrBit();
		logic bitOut;
		logic feedback;
		bitOut = lfsrState[15];
		feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		return bitOut;
	endfunction

	function automatic logic [15:0] randomOperand();
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < 16; i++) begin
			value = {value[14:0], nextLfsrBit()};	// One step per bit
		end
		return value;
	endfunction

	// Signed product added into the running sum, int wraps at 32 bits
	function automatic void addToModel(input operandT a, input operandT b);
		modelSum = modelSum + int'(a) * int'(b);
	endfunction

	function automatic axiDataT statusWord(input int count, input bit empty, input bit full);
		axiDataT word;
		word = '0;
		word[7:0] = count[7:0];
		word[STAT_EMPTY_BIT] = empty;
		word[STAT_FULL_BIT] = full;
		return word;
	endfunction

	////////////////////
	// AXI4-Lite master
	task automatic axiWrite(input regAddrT addr, input axiDataT data);
		int cycles;
		logic seen;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			seen = awready && wready;
			cycles++;
		end
		if (!seen) timedOut("AWREADY and WREADY");
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			seen = bvalid;
			cycles++;
		end
		if (!seen) timedOut("BVALID");
		checkValue("BRESP", axiDataT'(bresp), axiDataT'(AXI_OKAY));
		@(posedge clock);
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input regAddrT addr, output axiDataT data);
		int cycles;
		logic seen;
		araddr = addr;
		arvalid = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			seen = arready;
			cycles++;
		end
		if (!seen) timedOut("ARREADY");
		@(posedge clock);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			seen = rvalid;
			cycles++;
		end
		if (!seen) timedOut("RVALID");
		data = rdata;
		checkValue("RRESP", axiDataT'(rresp), axiDataT'(AXI_OKAY));
		@(posedge clock);
		#1;
		rready = 1'b0;
	endtask

	task automatic checkRead(input string what, input regAddrT addr, input axiDataT exp);
		axiDataT got;
		axiRead(addr, got);
		checkValue(what, got, exp);
	endtask

	// Low half a, high half b
	task automatic writePair(input operandT a, input operandT b);
		axiWrite(ADDR_OPERAND, {b, a});
		addToModel(a, b);
	endtask

	task automatic writeRandomPairs(input int n);
		operandT a;
		operandT b;
		for (int i = 0; i < n; i++) begin
			a = randomOperand();
			b = randomOperand();
			writePair(a, b);
		end
	endtask

	task automatic waitEmpty();
		axiDataT word;
		int polls;
		word = '0;
		polls = 0;
		while (!word[STAT_EMPTY_BIT] && polls < POLL_LIMIT) begin
			axiRead(ADDR_STATUS, word);
			polls++;
		end
		if (!word[STAT_EMPTY_BIT]) timedOut("the queue to drain");
	endtask

	////////////////////
	// Tests
	task automatic resetStateTest();
		checkRead("STATUS after reset", ADDR_STATUS, statusWord(0, 1'b1, 1'b0));
		checkRead("RESULT after reset", ADDR_RESULT, '0);
		checkRead("CONTROL after reset", ADDR_CONTROL, '0);
	endtask

	task automatic streamTest();
		modelSum = 0;
		axiWrite(ADDR_CONTROL, 32'h1);
		writeRandomPairs(3 * DEPTH);	// Pointers wrap more than once
		waitEmpty();
		checkRead("RESULT after streaming", ADDR_RESULT, axiDataT'(modelSum));
	endtask

	task automatic fillTest();
		axiWrite(ADDR_CONTROL, 32'h0);
		axiWrite(ADDR_CONTROL, 32'h2);
		modelSum = 0;
		writeRandomPairs(DEPTH);
		checkRead("STATUS when full", ADDR_STATUS, statusWord(DEPTH, 1'b0, 1'b1));
		checkRead("RESULT while disabled", ADDR_RESULT, '0);
	endtask

	task automatic backPressureTest();
		operandT a;
		operandT b;
		a = randomOperand();
		b = randomOperand();
		awaddr = ADDR_OPERAND;
		wdata = {b, a};
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		for (int i = 0; i < STALL_CYCLES; i++) begin
			@(negedge clock);
			assert (!awready && !wready) else begin
				$display("ERR %0.1f ns: operand write accepted while the queue was full",
					$realtime);
				stopRun();
			end
		end
		// Withdraw it, the single write channel is needed to set enable
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		axiWrite(ADDR_CONTROL, 32'h1);
		writePair(a, b);	// Completes once the engine frees a slot
		waitEmpty();
		checkRead("RESULT after back-pressure", ADDR_RESULT, axiDataT'(modelSum));
	endtask

	task automatic clearTest();
		axiWrite(ADDR_CONTROL, 32'h2);
		modelSum = 0;
		checkRead("RESULT after clear", ADDR_RESULT, '0);
		checkRead("CONTROL after clear", ADDR_CONTROL, 32'h1);	// Enable kept
		writeRandomPairs(5);
		waitEmpty();
		checkRead("RESULT after clear and 5 pairs", ADDR_RESULT, axiDataT'(modelSum));
	endtask

	initial begin
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		lfsrState = 16'd32820;
		modelSum = 0;
		failed = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		resetStateTest();
		streamTest();
		fillTest();
		backPressureTest();
		clearTest();
		if (!failed) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stopRun();
		end
	end

endmodule

// File: dotEngineTop.sv
////////////////////
// Streaming dot-product engine behind one AXI4-Lite slave
// DEPTH sets the operand queue size, power of two from 4 to 128
////////////////////
module dotEngineTop import blasPkg::*; #(
	parameter int DEPTH = 8
) (
	input logic clock,
	input logic reset,
	input logic awvalid,
	output logic awready,
	input regAddrT awaddr,
	input logic wvalid,
	output logic wready,
	input axiDataT wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input regAddrT araddr,
	output logic rvalid,
	input logic rready,
	output axiDataT rdata,
	output logic [1:0] rresp
);

	// Producer to buffer
	logic push;
	operandPairT pushData;
	queueStatusT queueStatus;
	// Buffer to consumer
	logic pop;
	operandPairT popData;
	// Control and result
	logic enable;
	logic clear;
	accumT result;

	axiLiteRegs u_axiLiteRegs (
		.clock(clock),
		.reset(reset),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.push(push),
		.pushData(pushData),
		.queueStatus(queueStatus),
		.result(result),
		.enable(enable),
		.clear(clear)
	);

	operandQueue #(
		.DEPTH(DEPTH)
	) u_operandQueue (
		.clock(clock),
		.reset(reset),
		.push(push),
		.pushData(pushData),
		.pop(pop),
		.popData(popData),
		.status(queueStatus)
	);

	dotAccumulator u_dotAccumulator (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.clear(clear),
		.queueStatus(queueStatus),
		.popData(popData),
		.pop(pop),
		.result(result)
	);

endmodule

// File: dotAccumulator.sv
////////////////////
// Two-stage MAC, product registered then added, up to two pairs in flight
// Result is final two cycles after the last pop
// Clear zeros the sum and drops the pair popped in the clear cycle
////////////////////
module dotAccumulator import blasPkg::*; (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic clear,
	input queueStatusT queueStatus,
	input operandPairT popData,		// Queue head, combinational
	output logic pop,
	output accumT result
);

	productT product;		// Stage 1 payload
	logic productValid;

	// Drain whenever allowed and something is queued
	assign pop = enable && !queueStatus.empty;

	////////////////////
	// Stage 1, multiply
	always_ff @(posedge clock) begin
		if (pop) begin
			// Widen first so the multiply runs at 32 bits
			product <= productT'(popData.a) * productT'(popData.b);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			productValid <= 1'b0;
		end else if (clear) begin
			productValid <= 1'b0;	// Pending product discarded
		end else begin
			productValid <= pop;
		end
	end

	////////////////////
	// Stage 2, accumulate
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			result <= '0;		// Clear wins over an add
		end else if (productValid) begin
			result <= result + accumT'(product);	// Wraps at 32 bits
		end
	end

endmodule

// File: axiLiteRegs.sv
////////////////////
// AXI4-Lite slave, one outstanding write and one outstanding read
// Operand writes stall with AWREADY and WREADY low while the queue is full
// A control write with the clear bit set leaves enable unchanged
// Control is updated only when WSTRB[0] is set, responses are always OKAY
////////////////////
module axiLiteRegs import blasPkg::*; (
	input logic clock,
	input logic reset,
	// Write address and data
	input logic awvalid,
	output logic awready,
	input regAddrT awaddr,
	input logic wvalid,
	output logic wready,
	input axiDataT wdata,
	input logic [3:0] wstrb,
	// Write response
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	// Read address and data
	input logic arvalid,
	output logic arready,
	input regAddrT araddr,
	output logic rvalid,
	input logic rready,
	output axiDataT rdata,
	output logic [1:0] rresp,
	// Engine side
	output logic push,
	output operandPairT pushData,
	input queueStatusT queueStatus,
	input accumT result,
	output logic enable,
	output logic clear
);

	axiWrStateT wrState;
	axiRdStateT rdState;
	logic opStall;		// Operand write blocked by a full queue
	logic wrAccept;		// AW and W handshake this cycle
	logic ctrlWrite;
	logic rdAccept;
	axiDataT rdWord;	// Read mux output

	////////////////////
	// Write channel
	assign opStall = (awaddr == ADDR_OPERAND) && queueStatus.full;
	assign wrAccept = (wrState == wrIdle) && awvalid && wvalid && !opStall;
	assign awready = wrAccept;	// AW and W always accepted together
	assign wready = wrAccept;
	assign bvalid = (wrState == wrResponse);
	assign bresp = RESP_OKAY;

	always_ff @(posedge clock) begin
		if (reset) begin
			wrState <= wrIdle;
		end else begin
			unique case (wrState)
				wrIdle: if (wrAccept) wrState <= wrResponse;
				wrResponse: if (bready) wrState <= wrIdle;
				default: wrState <= wrIdle;
			endcase
		end
	end

	// Operand push happens in the handshake cycle
	assign push = wrAccept && (awaddr == ADDR_OPERAND);

	always_comb begin
		pushData.a = operandT'(wdata[15:0]);
		pushData.b = operandT'(wdata[31:16]);
	end

	// Control bits, writes to RO addresses fall through
	assign ctrlWrite = wrAccept && (awaddr == ADDR_CONTROL) && wstrb[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			enable <= 1'b0;
			clear <= 1'b0;
		end else begin
			clear <= 1'b0;	// One-cycle pulse
			if (ctrlWrite) begin
				if (wdata[CTRL_CLEAR_BIT]) begin
					clear <= 1'b1;	// Enable kept as is
				end else begin
					enable <= wdata[CTRL_ENABLE_BIT];
				end
			end
		end
	end

	////////////////////
	// Read channel
	assign rdAccept = (rdState == rdIdle) && arvalid;
	assign arready = rdAccept;
	assign rvalid = (rdState == rdData);
	assign rresp = RESP_OKAY;

	always_ff @(posedge clock) begin
		if (reset) begin
			rdState <= rdIdle;
		end else begin
			unique case (rdState)
				rdIdle: if (rdAccept) rdState <= rdData;
				rdData: if (rready) rdState <= rdIdle;
				default: rdState <= rdIdle;
			endcase
		end
	end

	always_comb begin
		rdWord = '0;
		case (araddr)
			ADDR_CONTROL: rdWord[CTRL_ENABLE_BIT] = enable;
			ADDR_STATUS: begin
				rdWord[$bits(queueCountT)-1:0] = queueStatus.count;
				rdWord[STAT_EMPTY_BIT] = queueStatus.empty;
				rdWord[STAT_FULL_BIT] = queueStatus.full;
			end
			ADDR_RESULT: rdWord = axiDataT'(result);
			default: rdWord = '0;	// Operand register reads as zero
		endcase
	end

	// Snapshot at ARREADY, held for the whole R beat
	always_ff @(posedge clock) begin
		if (rdAccept) begin
			rdata <= rdWord;
		end
	end

	// Response channels stay up until the master takes them
	bHold: assert property (
		@(posedge clock) disable iff (reset)
		(bvalid && !bready) |=> bvalid
	) else $error("BVALID dropped before BREADY");

	rHold: assert property (
		@(posedge clock) disable iff (reset)
		(rvalid && !rready) |=> (rvalid && $stable(rdata))
	) else $error("RVALID or RDATA changed before RREADY");

endmodule

// File: operandQueue.sv
////////////////////
// DEPTH is a power of two, 4 to 128
// popData shows the head entry combinationally, valid only while not empty
// Pushing while full is not allowed, the writer must check status.full
////////////////////
module operandQueue import blasPkg::*; #(
	parameter int DEPTH = 8,
	localparam int PTR_W = $clog2(DEPTH)
) (
	input logic clock,
	input logic reset,
	input logic push,
	input operandPairT pushData,
	input logic pop,
	output operandPairT popData,		// Head of queue
	output queueStatusT status
);

	operandPairT store [DEPTH];	// Entry array, contents only meaningful below count

	logic [PTR_W-1:0] wAddr;
	logic [PTR_W-1:0] rAddr;
	logic [PTR_W:0] count;
	logic full;
	logic empty;

	// Pointer bookkeeping
	ringBuffCtrl #(
		.DEPTH(DEPTH)
	) u_ringBuffCtrl (
		.clock(clock),
		.reset(reset),
		.we(push),
		.re(pop),
		.wAddr(wAddr),
		.rAddr(rAddr),
		.count(count),
		.full(full),
		.empty(empty)
	);

	////////////////////
	// Storage
	always_ff @(posedge clock) begin
		if (push) begin
			store[wAddr] <= pushData;
		end
	end

	assign popData = store[rAddr];	// Unregistered read

	always_comb begin
		status.count = queueCountT'(count);	// Zero-extend to 8 bits
		status.empty = empty;
		status.full = full;
	end

	// Producer side back-pressure must already be in place
	noPushWhenFull: assert property (
		@(posedge clock) disable iff (reset)
		push |-> !full
	) else $error("push arrived while the queue was full");

endmodule

// File: ringBuffCtrl.sv
////////////////////
// DEPTH must be a power of two
// Writer must not assert we while full, nothing here blocks it
// A read while empty is dropped
////////////////////
module ringBuffCtrl #(
	parameter int DEPTH = 8,
	localparam int PTR_W = $clog2(DEPTH)
) (
	input logic clock,
	input logic reset,
	input logic we,						// Push strobe
	input logic re,						// Pop strobe
	output logic [PTR_W-1:0] wAddr,
	output logic [PTR_W-1:0] rAddr,
	output logic [PTR_W:0] count,		// Entries held, 0 to DEPTH
	output logic full,
	output logic empty
);

	localparam logic [PTR_W:0] FULL_COUNT = DEPTH[PTR_W:0];

	// Pointers carry one extra wrap bit
	logic [PTR_W:0] wPtr;
	logic [PTR_W:0] rPtr;
	logic doRead;	// Qualified read

	////////////////////
	// Status
	assign count = wPtr - rPtr;		// Modulo 2*DEPTH, wrap bit resolves full vs empty
	assign full = (count == FULL_COUNT);
	assign empty = (count == '0);
	assign doRead = re && !empty;

	// Storage addresses drop the wrap bit
	assign wAddr = wPtr[PTR_W-1:0];
	assign rAddr = rPtr[PTR_W-1:0];

	////////////////////
	// Pointer registers
	always_ff @(posedge clock) begin
		if (reset) begin
			wPtr <= '0;
		end else if (we) begin
			wPtr <= wPtr + 1'b1;	// Rolls over through the wrap bit
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rPtr <= '0;
		end else if (doRead) begin
			rPtr <= rPtr + 1'b1;
		end
	end

	// Holding off pushes is up to the producer upstream
	wrHoldWhileFull: assert property (
		@(posedge clock) disable iff (reset)
		full |=> (wPtr == $past(wPtr))
	) else $error("write pointer advanced while the ring was full");

endmodule

// File: blasPkg.sv
////////////////////
// Operands are signed 16 bit, products and the accumulator signed 32 bit
// Accumulator wraps on overflow, no saturation
// Register addresses are 4-bit byte addresses, word aligned only
// Queue count field is 8 bits wide, enough for a depth of 128
////////////////////
package blasPkg;

	////////////////////
	// Data widths
	typedef logic signed [15:0] operandT;	// One operand
	typedef logic signed [31:0] productT;	// Full-width product of a pair
	typedef logic signed [31:0] accumT;		// Wraps
	typedef logic [3:0] regAddrT;			// AXI4-Lite byte address
	typedef logic [31:0] axiDataT;			// AXI4-Lite data word
	typedef logic [7:0] queueCountT;		// 0 up to 128 entries

	// One queue entry, a in the upper half of the packed vector
	typedef struct packed {
		operandT a;
		operandT b;
	} operandPairT;

	typedef struct packed {
		queueCountT count;
		logic empty;
		logic full;
	} queueStatusT;

	////////////////////
	// Register map
	localparam regAddrT ADDR_OPERAND = 4'h0;	// WO, a in [15:0], b in [31:16]
	localparam regAddrT ADDR_CONTROL = 4'h4;	// RW enable, WO clear
	localparam regAddrT ADDR_STATUS = 4'h8;		// RO
	localparam regAddrT ADDR_RESULT = 4'hC;		// RO accumulator

	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT = 1;	// Self-clearing
	localparam int STAT_EMPTY_BIT = 16;
	localparam int STAT_FULL_BIT = 17;

	localparam logic [1:0] RESP_OKAY = 2'b00;	// Only response ever returned

	// Channel state machines
	typedef enum logic {wrIdle, wrResponse} axiWrStateT;
	typedef enum logic {rdIdle, rdData} axiRdStateT;

endpackage
